// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/core_if.sv
      - source/insn_decode.sv
      - source/reg_rename_file.sv
      - source/alu_execute.sv
      - source/reorder_buffer.sv
      - source/ooo_core_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_ooo_core.sv

// ==== compile.f ====
+incdir+source
source/core_pkg.sv
source/core_if.sv
source/insn_decode.sv
source/reg_rename_file.sv
source/alu_execute.sv
source/reorder_buffer.sv
source/ooo_core_top.sv
test/tb_ooo_core.sv

// ==== source/alu_execute.sv ====
`include "core_defines.svh"
`default_nettype none

module alu_execute (
  operand_if.sink  opd,
  result_if.source res
);

  core_pkg::data_t a;
  core_pkg::data_t b;
  core_pkg::data_t sum;
  core_pkg::data_t diff;
  logic            carry_add;
  logic            carry_sub;
  logic            v_add;
  logic            v_sub;
  core_pkg::nzcv_t flags_in;
  logic            cond_ok;

  // Pending operands are fetched from the reorder buffer by tag
  assign res.rd_tag1     = opd.src1_tag;
  assign res.rd_tag2     = opd.src2_tag;
  assign res.rd_nzcv_tag = opd.nzcv_tag;

  assign a        = opd.src1_valid ? opd.src1_value : res.rd_value1;
  assign b        = opd.src2_valid ? opd.src2_value : res.rd_value2;
  assign flags_in = opd.nzcv_valid ? opd.nzcv : res.rd_nzcv;

  assign {carry_add, sum}  = {1'b0, a} + {1'b0, b};
  // Carry set means no borrow
  assign {carry_sub, diff} = {1'b0, a} + {1'b0, ~b} + 1'b1;

  assign v_add = (a[`DATA_WIDTH-1] == b[`DATA_WIDTH-1]) &&
                 (sum[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
  assign v_sub = (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1]) &&
                 (diff[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);

  always_comb begin
    case (opd.cond)
      core_pkg::COND_EQ: cond_ok = flags_in[2];
      core_pkg::COND_NE: cond_ok = !flags_in[2];
      core_pkg::COND_LT: cond_ok = (flags_in[3] != flags_in[0]);
      core_pkg::COND_GE: cond_ok = (flags_in[3] == flags_in[0]);
      default:           cond_ok = 1'b0;
    endcase
  end

  always_comb begin
    res.done     = opd.done;
    res.tag      = opd.tag;
    res.set_nzcv = opd.set_nzcv;
    case (opd.op)
      core_pkg::FU_OP_ADD, core_pkg::FU_OP_ADDI, core_pkg::FU_OP_ADDS: res.value = sum;
      core_pkg::FU_OP_SUB, core_pkg::FU_OP_SUBI, core_pkg::FU_OP_SUBS: res.value = diff;
      core_pkg::FU_OP_AND:  res.value = a & b;
      core_pkg::FU_OP_ORR:  res.value = a | b;
      core_pkg::FU_OP_CSEL: res.value = cond_ok ? a : b;
      default:              res.value = '0;
    endcase
    // Flags only matter when set_nzcv is high
    if (opd.op == core_pkg::FU_OP_SUBS) begin
      res.nzcv = {diff[`DATA_WIDTH-1], (diff == '0), carry_sub, v_sub};
    end else begin
      res.nzcv = {sum[`DATA_WIDTH-1], (sum == '0), carry_add, v_add};
    end
  end

endmodule

`default_nettype wire

// ==== source/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and register file sizes
`define DATA_WIDTH    32
`define GPR_COUNT     16
`define GPR_IDX_SIZE  4
// Reads as zero, writes are dropped
`define XZR_IDX       15

// Reorder buffer sizes
`define ROB_DEPTH     8
`define ROB_IDX_SIZE  3

// Immediate is zero-extended to DATA_WIDTH
`define IMM_SIZE      12
`define INSN_WIDTH    32

// Instruction word layout
`define OPCODE_MSB    31
`define OPCODE_LSB    28
`define DST_MSB       27
`define DST_LSB       24
`define SRC1_MSB      23
`define SRC1_LSB      20
`define SRC2_MSB      19
`define SRC2_LSB      16
`define COND_MSB      15
`define COND_LSB      12
`define IMM_MSB       11
`define IMM_LSB       0

`endif

// ==== source/core_if.sv ====
`default_nettype none

// Decoded instruction, decode to register file
interface dispatch_if;
  logic               done;
  core_pkg::fu_op_t   op;
  core_pkg::gpr_idx_t dst;
  core_pkg::gpr_idx_t src1;
  core_pkg::gpr_idx_t src2;
  core_pkg::imm_t     imm;
  core_pkg::cond_t    cond;
  logic               use_imm;
  logic               set_nzcv;
  logic               uses_nzcv;

  modport source (
    output done, op, dst, src1, src2, imm, cond, use_imm, set_nzcv, uses_nzcv
  );
  modport sink (
    input done, op, dst, src1, src2, imm, cond, use_imm, set_nzcv, uses_nzcv
  );
endinterface

// Renamed operands, register file to execute
interface operand_if;
  logic               done;
  core_pkg::fu_op_t   op;
  core_pkg::cond_t    cond;
  logic               set_nzcv;
  core_pkg::rob_idx_t tag;
  core_pkg::gpr_idx_t dst;
  logic               src1_valid;
  core_pkg::data_t    src1_value;
  core_pkg::rob_idx_t src1_tag;
  logic               src2_valid;
  core_pkg::data_t    src2_value;
  core_pkg::rob_idx_t src2_tag;
  logic               nzcv_valid;
  core_pkg::nzcv_t    nzcv;
  core_pkg::rob_idx_t nzcv_tag;

  modport source (
    output done, op, cond, set_nzcv, tag, dst,
    output src1_valid, src1_value, src1_tag,
    output src2_valid, src2_value, src2_tag,
    output nzcv_valid, nzcv, nzcv_tag
  );
  modport sink (
    input done, op, cond, set_nzcv, tag, dst,
    input src1_valid, src1_value, src1_tag,
    input src2_valid, src2_value, src2_tag,
    input nzcv_valid, nzcv, nzcv_tag
  );
endinterface

// ALU result plus the tag-indexed read port of the reorder buffer
interface result_if;
  logic               done;
  core_pkg::rob_idx_t tag;
  core_pkg::data_t    value;
  core_pkg::nzcv_t    nzcv;
  logic               set_nzcv;
  core_pkg::rob_idx_t rd_tag1;
  core_pkg::rob_idx_t rd_tag2;
  core_pkg::rob_idx_t rd_nzcv_tag;
  core_pkg::data_t    rd_value1;
  core_pkg::data_t    rd_value2;
  core_pkg::nzcv_t    rd_nzcv;

  modport source (
    output done, tag, value, nzcv, set_nzcv, rd_tag1, rd_tag2, rd_nzcv_tag,
    input  rd_value1, rd_value2, rd_nzcv
  );
  modport sink (
    input  done, tag, value, nzcv, set_nzcv, rd_tag1, rd_tag2, rd_nzcv_tag,
    output rd_value1, rd_value2, rd_nzcv
  );
endinterface

// In-order retirement, reorder buffer to register file
interface commit_if;
  logic               done;
  core_pkg::gpr_idx_t reg_index;
  core_pkg::rob_idx_t tag;
  core_pkg::data_t    value;
  logic               set_nzcv;
  core_pkg::nzcv_t    nzcv;

  modport source (output done, reg_index, tag, value, set_nzcv, nzcv);
  modport sink (input done, reg_index, tag, value, set_nzcv, nzcv);
endinterface

`default_nettype wire

// ==== source/core_pkg.sv ====
`include "core_defines.svh"
`default_nettype none

package core_pkg;

  typedef logic [`DATA_WIDTH-1:0]   data_t;
  typedef logic [`GPR_IDX_SIZE-1:0] gpr_idx_t;
  typedef logic [`ROB_IDX_SIZE-1:0] rob_idx_t;
  typedef logic [`IMM_SIZE-1:0]     imm_t;
  typedef logic [`INSN_WIDTH-1:0]   insn_t;

  // Packed as {N, Z, C, V}
  typedef logic [3:0] nzcv_t;

  // Encodings match the opcode field of the instruction word
  typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
    FU_OP_ADD  = 4'd0,
    FU_OP_SUB  = 4'd1,
    FU_OP_AND  = 4'd2,
    FU_OP_ORR  = 4'd3,
    FU_OP_ADDI = 4'd4,
    FU_OP_SUBI = 4'd5,
    FU_OP_ADDS = 4'd6,
    FU_OP_SUBS = 4'd7,
    FU_OP_CSEL = 4'd8,
    FU_OP_NOP  = 4'd9
  } fu_op_t;

  // Conditions tested by CSEL
  typedef enum logic [`COND_MSB-`COND_LSB:0] {
    COND_EQ = 4'd0,
    COND_NE = 4'd1,
    // Signed less than, N differs from V
    COND_LT = 4'd2,
    COND_GE = 4'd3
  } cond_t;

endpackage

`default_nettype wire

// ==== source/insn_decode.sv ====
`include "core_defines.svh"
`default_nettype none

module insn_decode (
  input  logic            in_clk,
  input  logic            in_rst,
  input  logic            insn_valid,
  input  core_pkg::insn_t insn,
  dispatch_if.source      dsp
);

  logic             valid_q;
  core_pkg::insn_t  insn_q;
  core_pkg::fu_op_t dec_op;
  logic             known_op;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= insn_valid;
    end
  end

  // Word is held until the next strobe
  always_ff @(posedge in_clk) begin
    if (insn_valid) begin
      insn_q <= insn;
    end
  end

  always_comb begin
    known_op = (insn_q[`OPCODE_MSB:`OPCODE_LSB] <= core_pkg::FU_OP_NOP);
    // Opcodes past NOP decode as NOP
    dec_op = known_op ? core_pkg::fu_op_t'(insn_q[`OPCODE_MSB:`OPCODE_LSB])
                      : core_pkg::FU_OP_NOP;

    dsp.done = valid_q;
    dsp.op   = dec_op;
    // A NOP writes nothing, so steer it to XZR
    dsp.dst  = (dec_op == core_pkg::FU_OP_NOP) ? core_pkg::gpr_idx_t'(`XZR_IDX)
                                               : insn_q[`DST_MSB:`DST_LSB];
    dsp.src1 = insn_q[`SRC1_MSB:`SRC1_LSB];
    dsp.src2 = insn_q[`SRC2_MSB:`SRC2_LSB];
    dsp.imm  = insn_q[`IMM_MSB:`IMM_LSB];
    dsp.cond = core_pkg::cond_t'(insn_q[`COND_MSB:`COND_LSB]);

    dsp.use_imm   = (dec_op == core_pkg::FU_OP_ADDI) || (dec_op == core_pkg::FU_OP_SUBI);
    dsp.set_nzcv  = (dec_op == core_pkg::FU_OP_ADDS) || (dec_op == core_pkg::FU_OP_SUBS);
    dsp.uses_nzcv = (dec_op == core_pkg::FU_OP_CSEL);
  end

endmodule

`default_nettype wire

// ==== source/ooo_core_top.sv ====
`default_nettype none

module ooo_core_top (
  input  logic               in_clk,
  input  logic               in_rst,
  input  logic               insn_valid,
  input  core_pkg::insn_t    insn,
  output logic               commit_valid,
  output core_pkg::gpr_idx_t commit_reg,
  output core_pkg::data_t    commit_value,
  output core_pkg::nzcv_t    commit_nzcv,
  output logic               commit_set_nzcv
);

  dispatch_if dsp_bus ();
  operand_if  opd_bus ();
  result_if   res_bus ();
  commit_if   cmt_bus ();

  core_pkg::rob_idx_t alloc_tag;

  insn_decode u_decode (
    .in_clk     (in_clk),
    .in_rst     (in_rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .dsp        (dsp_bus.source)
  );

  reg_rename_file u_regs (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .dsp       (dsp_bus.sink),
    .opd       (opd_bus.source),
    .cmt       (cmt_bus.sink),
    .alloc_tag (alloc_tag)
  );

  alu_execute u_alu (
    .opd (opd_bus.sink),
    .res (res_bus.source)
  );

  // Entries are allocated in the operand cycle
  reorder_buffer u_rob (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .dsp_done  (opd_bus.done),
    .dst       (opd_bus.dst),
    .res       (res_bus.sink),
    .cmt       (cmt_bus.source),
    .alloc_tag (alloc_tag)
  );

  assign commit_valid    = cmt_bus.done;
  assign commit_reg      = cmt_bus.reg_index;
  assign commit_value    = cmt_bus.value;
  assign commit_nzcv     = cmt_bus.nzcv;
  assign commit_set_nzcv = cmt_bus.set_nzcv;

endmodule

`default_nettype wire

// ==== source/reg_rename_file.sv ====
`include "core_defines.svh"
`default_nettype none

module reg_rename_file (
  input  logic               in_clk,
  input  logic               in_rst,
  dispatch_if.sink           dsp,
  operand_if.source          opd,
  commit_if.sink             cmt,
  input  core_pkg::rob_idx_t alloc_tag
);

  // Architectural state with rename tags
  core_pkg::data_t       gpr_value [`GPR_COUNT];
  logic [`GPR_COUNT-1:0] gpr_valid;
  core_pkg::rob_idx_t    gpr_tag [`GPR_COUNT];
  core_pkg::nzcv_t       nzcv_value;
  logic                  nzcv_valid;
  core_pkg::rob_idx_t    nzcv_tag;

  // Buffered dispatch
  logic               d_done;
  core_pkg::fu_op_t   d_op;
  core_pkg::gpr_idx_t d_dst;
  core_pkg::gpr_idx_t d_src1;
  core_pkg::gpr_idx_t d_src2;
  core_pkg::imm_t     d_imm;
  core_pkg::cond_t    d_cond;
  logic               d_use_imm;
  logic               d_set_nzcv;
  logic               d_uses_nzcv;

  logic reg_commit;
  logic flag_commit;

  // Commit lands only if no younger writer renamed the target since
  assign reg_commit  = cmt.done && (cmt.reg_index != core_pkg::gpr_idx_t'(`XZR_IDX))
                       && (cmt.tag == gpr_tag[cmt.reg_index]);
  assign flag_commit = cmt.done && cmt.set_nzcv && (cmt.tag == nzcv_tag);

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      d_done     <= 1'b0;
      gpr_valid  <= '1;
      nzcv_value <= '0;
      nzcv_valid <= 1'b1;
      nzcv_tag   <= '0;
      for (int i = 0; i < `GPR_COUNT; i++) begin
        gpr_value[i] <= '0;
        gpr_tag[i]   <= '0;
      end
    end else begin
      d_done <= dsp.done;
      if (reg_commit) begin
        gpr_value[cmt.reg_index] <= cmt.value;
        gpr_valid[cmt.reg_index] <= 1'b1;
      end
      if (flag_commit) begin
        nzcv_value <= cmt.nzcv;
        nzcv_valid <= 1'b1;
      end
      // Rename comes last so it overrides a same-cycle commit
      if (d_done && (d_dst != core_pkg::gpr_idx_t'(`XZR_IDX))) begin
        gpr_valid[d_dst] <= 1'b0;
        gpr_tag[d_dst]   <= alloc_tag;
      end
      if (d_done && d_set_nzcv) begin
        nzcv_valid <= 1'b0;
        nzcv_tag   <= alloc_tag;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (dsp.done) begin
      d_op        <= dsp.op;
      d_dst       <= dsp.dst;
      d_src1      <= dsp.src1;
      d_src2      <= dsp.src2;
      d_imm       <= dsp.imm;
      d_cond      <= dsp.cond;
      d_use_imm   <= dsp.use_imm;
      d_set_nzcv  <= dsp.set_nzcv;
      d_uses_nzcv <= dsp.uses_nzcv;
    end
  end

  always_comb begin
    opd.done     = d_done;
    opd.op       = d_op;
    opd.cond     = d_cond;
    opd.set_nzcv = d_set_nzcv;
    opd.dst      = d_dst;
    // This instruction takes the next free entry
    opd.tag      = alloc_tag;

    opd.src1_tag = gpr_tag[d_src1];
    if (d_src1 == core_pkg::gpr_idx_t'(`XZR_IDX)) begin
      opd.src1_valid = 1'b1;
      opd.src1_value = '0;
    end else begin
      opd.src1_valid = gpr_valid[d_src1];
      opd.src1_value = gpr_value[d_src1];
    end

    opd.src2_tag = gpr_tag[d_src2];
    if (d_use_imm) begin
      opd.src2_valid = 1'b1;
      opd.src2_value = core_pkg::data_t'(d_imm);
    end else if (d_src2 == core_pkg::gpr_idx_t'(`XZR_IDX)) begin
      opd.src2_valid = 1'b1;
      opd.src2_value = '0;
    end else begin
      opd.src2_valid = gpr_valid[d_src2];
      opd.src2_value = gpr_value[d_src2];
    end

    // Only CSEL waits on pending flags
    opd.nzcv_valid = nzcv_valid || !d_uses_nzcv;
    opd.nzcv       = nzcv_value;
    opd.nzcv_tag   = nzcv_tag;
  end

endmodule

`default_nettype wire

// ==== source/reorder_buffer.sv ====
`include "core_defines.svh"
`default_nettype none

module reorder_buffer (
  input  logic               in_clk,
  input  logic               in_rst,
  input  logic               dsp_done,
  input  core_pkg::gpr_idx_t dst,
  result_if.sink             res,
  commit_if.source           cmt,
  output core_pkg::rob_idx_t alloc_tag
);

  // Entry payload
  core_pkg::gpr_idx_t    e_dst [`ROB_DEPTH];
  core_pkg::data_t       e_value [`ROB_DEPTH];
  core_pkg::nzcv_t       e_nzcv [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] e_set_nzcv;
  // Result written and not yet retired
  logic [`ROB_DEPTH-1:0] e_done;

  core_pkg::rob_idx_t head;
  core_pkg::rob_idx_t tail;
  logic               retire;

  assign alloc_tag = tail;
  assign retire    = e_done[head];

  // Retired data stays readable until the entry is reused
  assign res.rd_value1 = e_value[res.rd_tag1];
  assign res.rd_value2 = e_value[res.rd_tag2];
  assign res.rd_nzcv   = e_nzcv[res.rd_nzcv_tag];

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      head     <= '0;
      tail     <= '0;
      e_done   <= '0;
      cmt.done <= 1'b0;
    end else begin
      cmt.done <= retire;
      if (dsp_done) begin
        tail <= tail + 1'b1;
      end
      if (retire) begin
        head         <= head + 1'b1;
        e_done[head] <= 1'b0;
      end
      // Result arrives in the allocation cycle of its entry
      if (res.done) begin
        e_done[res.tag] <= 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (dsp_done) begin
      e_dst[tail] <= dst;
    end
    if (res.done) begin
      e_value[res.tag]    <= res.value;
      e_nzcv[res.tag]     <= res.nzcv;
      e_set_nzcv[res.tag] <= res.set_nzcv;
    end
    // Registered commit report
    if (retire) begin
      cmt.reg_index <= e_dst[head];
      cmt.tag       <= head;
      cmt.value     <= e_value[head];
      cmt.set_nzcv  <= e_set_nzcv[head];
      cmt.nzcv      <= e_nzcv[head];
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_ooo_core.sv ====
`include "core_defines.svh"
`default_nettype none

module tb_ooo_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_GAP = -1;
  localparam int LATENCY  = 4;

  logic               in_clk;
  logic               in_rst;
  logic               insn_valid;
  core_pkg::insn_t    insn;
  logic               commit_valid;
  core_pkg::gpr_idx_t commit_reg;
  core_pkg::data_t    commit_value;
  core_pkg::nzcv_t    commit_nzcv;
  logic               commit_set_nzcv;

  // Program table
  string       step_name [$];
  logic [31:0] step_word [$];
  int          step_gap  [$];

  // Expected commits queued at issue and popped by the monitor
  string       exp_name  [$];
  logic [3:0]  exp_reg   [$];
  logic [31:0] exp_value [$];
  logic        exp_set   [$];
  logic [3:0]  exp_nzcv  [$];
  int          exp_issue [$];

  // Reference state
  logic [31:0] model_gpr [16];
  logic [3:0]  model_nzcv;

  int cycle = 0;
  int cycle_limit = 0;
  bit limit_ready = 0;
  int mismatch_count = 0;
  int other_count = 0;
  int commit_count = 0;

  ooo_core_top DUT (
    .in_clk          (in_clk),
    .in_rst          (in_rst),
    .insn_valid      (insn_valid),
    .insn            (insn),
    .commit_valid    (commit_valid),
    .commit_reg      (commit_reg),
    .commit_value    (commit_value),
    .commit_nzcv     (commit_nzcv),
    .commit_set_nzcv (commit_set_nzcv)
  );

  initial begin
    in_clk = 1'b0;
    forever #2 in_clk = ~in_clk;
  end

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [3:0] dst,
                                         input logic [3:0] src1, input logic [3:0] src2,
                                         input logic [3:0] cond, input logic [11:0] imm);
    logic [31:0] w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB] = op;
    w[`DST_MSB:`DST_LSB]       = dst;
    w[`SRC1_MSB:`SRC1_LSB]     = src1;
    w[`SRC2_MSB:`SRC2_LSB]     = src2;
    w[`COND_MSB:`COND_LSB]     = cond;
    w[`IMM_MSB:`IMM_LSB]       = imm;
    return w;
  endfunction

  task automatic add_step(input string name, input logic [31:0] word, input int gap);
    step_name.push_back(name);
    step_word.push_back(word);
    step_gap.push_back(gap);
  endtask

  task automatic build_program();
    // Fresh registers all read zero
    add_step("read_zero_a", encode(core_pkg::FU_OP_ORR, 0, 13, 14, 0, 0), 1);
    add_step("read_zero_b", encode(core_pkg::FU_OP_ADD, 1, 12, 11, 0, 0), 0);
    add_step("addi_xzr_src", encode(core_pkg::FU_OP_ADDI, 1, 15, 0, 0, 12'h123), 0);
    // Each source is the previous destination
    add_step("chain_add", encode(core_pkg::FU_OP_ADD, 2, 1, 1, 0, 0), 0);
    add_step("chain_sub", encode(core_pkg::FU_OP_SUB, 3, 2, 1, 0, 0), 0);
    add_step("chain_and", encode(core_pkg::FU_OP_AND, 4, 3, 2, 0, 0), 0);
    add_step("chain_orr", encode(core_pkg::FU_OP_ORR, 5, 4, 3, 0, 0), 1);
    add_step("subi_wrap", encode(core_pkg::FU_OP_SUBI, 6, 4, 0, 0, 12'h005), 0);
    add_step("xzr_write", encode(core_pkg::FU_OP_ADDI, 15, 5, 0, 0, 12'h7ff), 0);
    add_step("xzr_read", encode(core_pkg::FU_OP_ADD, 7, 15, 5, 0, 0), 0);
    // Flag producers with consumers right behind them
    add_step("subs_neg", encode(core_pkg::FU_OP_SUBS, 8, 1, 2, 0, 0), 0);
    add_step("csel_lt_now", encode(core_pkg::FU_OP_CSEL, 9, 1, 2, core_pkg::COND_LT, 0), 0);
    add_step("subs_eq", encode(core_pkg::FU_OP_SUBS, 15, 3, 1, 0, 0), 0);
    add_step("csel_eq_now", encode(core_pkg::FU_OP_CSEL, 10, 6, 7, core_pkg::COND_EQ, 0), 2);
    add_step("csel_ne_late", encode(core_pkg::FU_OP_CSEL, 11, 6, 7, core_pkg::COND_NE, 0), 0);
    // r14 renamed twice while its first writer is in flight
    add_step("stale_first", encode(core_pkg::FU_OP_ADDI, 14, 15, 0, 0, 12'h0aa), 0);
    add_step("stale_second", encode(core_pkg::FU_OP_ADDI, 14, 15, 0, 0, 12'h055), 1);
    // Operands read in the cycle after the first writer retires
    add_step("stale_read", encode(core_pkg::FU_OP_ADD, 0, 14, 15, 0, 0), RAND_GAP);
    add_step("subi_all_ones", encode(core_pkg::FU_OP_SUBI, 12, 15, 0, 0, 12'h001), RAND_GAP);
    add_step("adds_carry", encode(core_pkg::FU_OP_ADDS, 13, 12, 1, 0, 0), RAND_GAP);
    add_step("csel_ge", encode(core_pkg::FU_OP_CSEL, 2, 13, 0, core_pkg::COND_GE, 0), RAND_GAP);
    add_step("stale_late", encode(core_pkg::FU_OP_ORR, 3, 14, 2, 0, 0), RAND_GAP);
  endtask

  function automatic logic [31:0] read_gpr(input logic [3:0] idx);
    if (idx == `XZR_IDX) begin
      return '0;
    end
    return model_gpr[idx];
  endfunction

  function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
    case (cond)
      4'd0:    return f[2];
      4'd1:    return !f[2];
      4'd2:    return f[3] != f[0];
      4'd3:    return f[3] == f[0];
      default: return 1'b0;
    endcase
  endfunction

  // Applies one instruction to the reference state and queues its commit
  task automatic model_step(input string name, input logic [31:0] w, input int issue);
    logic [3:0]  op;
    logic [3:0]  dst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [3:0]  flags;
    logic        set;
    longint      wide;
    longint      sa;
    longint      sb;
    op    = w[`OPCODE_MSB:`OPCODE_LSB];
    dst   = w[`DST_MSB:`DST_LSB];
    a     = read_gpr(w[`SRC1_MSB:`SRC1_LSB]);
    b     = read_gpr(w[`SRC2_MSB:`SRC2_LSB]);
    sa    = $signed(a);
    sb    = $signed(b);
    value = '0;
    flags = '0;
    set   = 1'b0;
    if (op == core_pkg::FU_OP_ADDI || op == core_pkg::FU_OP_SUBI) begin
      b = {20'b0, w[`IMM_MSB:`IMM_LSB]};
    end
    case (op)
      core_pkg::FU_OP_ADD, core_pkg::FU_OP_ADDI: value = a + b;
      core_pkg::FU_OP_SUB, core_pkg::FU_OP_SUBI: value = a - b;
      core_pkg::FU_OP_AND:  value = a & b;
      core_pkg::FU_OP_ORR:  value = a | b;
      core_pkg::FU_OP_CSEL: value = cond_holds(w[`COND_MSB:`COND_LSB], model_nzcv) ? a : b;
      core_pkg::FU_OP_ADDS: begin
        value = a + b;
        wide  = longint'(a) + longint'(b);
        set   = 1'b1;
        // Overflow when the exact signed sum differs from the wrapped one
        flags = {value[31], value == 0, wide > 64'hffff_ffff,
                 (sa + sb) != longint'($signed(value))};
      end
      core_pkg::FU_OP_SUBS: begin
        value = a - b;
        set   = 1'b1;
        flags = {value[31], value == 0, a >= b,
                 (sa - sb) != longint'($signed(value))};
      end
      default: dst = `XZR_IDX;
    endcase
    if (dst != `XZR_IDX) begin
      model_gpr[dst] = value;
    end
    if (set) begin
      model_nzcv = flags;
    end
    exp_name.push_back(name);
    exp_reg.push_back(dst);
    exp_value.push_back(value);
    exp_set.push_back(set);
    exp_nzcv.push_back(flags);
    exp_issue.push_back(issue);
  endtask

  task automatic print_summary();
    $display("Summary: %0d commits checked, %0d mismatches, %0d other errors",
             commit_count, mismatch_count, other_count);
  endtask

  // Cycle count and run limit
  always @(posedge in_clk) begin
    cycle <= cycle + 1;
    if (limit_ready && cycle >= cycle_limit) begin
      other_count++;
      $display("ERROR: timeout after %0d cycles with %0d commits still expected",
               cycle, exp_reg.size());
      print_summary();
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Commit monitor samples mid-cycle
  always @(negedge in_clk) begin : commit_monitor
    string       name;
    logic [3:0]  e_reg;
    logic [31:0] e_value;
    logic        e_set;
    logic [3:0]  e_nzcv;
    int          issue;
    if (!in_rst && commit_valid !== 1'b0) begin
      if (commit_valid !== 1'b1) begin
        other_count++;
        $display("ERROR: commit_valid is unknown at cycle %0d", cycle);
      end else if (exp_reg.size() == 0) begin
        other_count++;
        $display("ERROR: commit at cycle %0d with no instruction outstanding", cycle);
      end else begin
        name    = exp_name.pop_front();
        e_reg   = exp_reg.pop_front();
        e_value = exp_value.pop_front();
        e_set   = exp_set.pop_front();
        e_nzcv  = exp_nzcv.pop_front();
        issue   = exp_issue.pop_front();
        commit_count++;
        if (commit_reg !== e_reg) begin
          mismatch_count++;
          $display("MISMATCH %s reg: expected %0d actual %0d", name, e_reg, commit_reg);
        end
        if (commit_value !== e_value) begin
          mismatch_count++;
          $display("MISMATCH %s value: expected %h actual %h", name, e_value, commit_value);
        end
        if (commit_set_nzcv !== e_set) begin
          mismatch_count++;
          $display("MISMATCH %s set_nzcv: expected %b actual %b", name, e_set, commit_set_nzcv);
        end
        // Flags are only meaningful on flag-setting ops
        if (e_set && commit_nzcv !== e_nzcv) begin
          mismatch_count++;
          $display("MISMATCH %s nzcv: expected %b actual %b", name, e_nzcv, commit_nzcv);
        end
        if (cycle - issue != LATENCY) begin
          other_count++;
          $display("ERROR: %s committed %0d cycles after issue instead of %0d",
                   name, cycle - issue, LATENCY);
        end
      end
    end
  end

  initial begin : stimulus
    int total_gap;
    in_rst     = 1'b1;
    insn_valid = 1'b0;
    insn       = '0;
    model_nzcv = '0;
    foreach (model_gpr[r]) begin
      model_gpr[r] = '0;
    end
    build_program();
    void'($urandom(17878));
    total_gap = 0;
    foreach (step_gap[i]) begin
      if (step_gap[i] == RAND_GAP) begin
        step_gap[i] = $urandom % 3;
      end
      total_gap += step_gap[i];
    end
    cycle_limit = step_word.size() + total_gap + 20;
    limit_ready = 1'b1;

    repeat (2) @(posedge in_clk);
    #1;
    in_rst = 1'b0;
    // No commit may appear while idle after reset
    repeat (3) @(posedge in_clk);

    for (int i = 0; i < step_word.size(); i++) begin
      @(posedge in_clk);
      #1;
      insn_valid = 1'b1;
      insn       = step_word[i];
      model_step(step_name[i], step_word[i], cycle);
      for (int g = 0; g < step_gap[i]; g++) begin
        @(posedge in_clk);
        #1;
        insn_valid = 1'b0;
      end
    end
    @(posedge in_clk);
    #1;
    insn_valid = 1'b0;

    while (exp_reg.size() != 0) begin
      @(posedge in_clk);
    end
    // A few more cycles to catch stray commits
    repeat (4) @(posedge in_clk);

    print_summary();
    if (mismatch_count == 0 && other_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
